//--- project.f
src/eth_pkg.sv
src/ip_pkg.sv
src/frame_demux.sv
src/frame_arbiter.sv
src/skid_register.sv
src/ip_steer_top.sv
test/tb_ip_steer.sv

//--- run.sh
#!/bin/sh
# Build and run the steering fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module tb_ip_steer -o tb_ip_steer

out=$(./obj_dir/tb_ip_steer) || true
printf '%s\n' "$out"

# Exits non-zero unless the pass line is present
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'

//--- src/eth_pkg.sv
// Ethernet header, ethertype numbers and payload beat for the steering fabric
`default_nettype none

package eth_pkg;

  // 64-bit payload datapath
  localparam int DATA_BYTES = 8;

  // Ethertypes the receive demux knows about
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;

  // 112 bits
  typedef struct packed {
    logic [47:0] dest_mac;
    logic [47:0] src_mac;
    logic [15:0] eth_type;
  } eth_hdr_t;

  // One payload beat, 74 bits
  typedef struct packed {
    logic [DATA_BYTES*8-1:0] data;
    logic [DATA_BYTES-1:0]   keep;
    logic                    last;
    // Frame error flag, meaningful on the last beat
    logic                    user;
  } beat_t;

endpackage

`default_nettype wire

//--- src/frame_arbiter.sv
// Merges two frame sources with fixed priority and holds the grant for a whole frame
`timescale 1ns/100ps
`default_nettype none

module frame_arbiter #(
  parameter type HDR_T = eth_pkg::eth_hdr_t
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire HDR_T           s0_hdr,
  input  wire                 s0_hdr_valid,
  output logic                s0_hdr_ready,
  input  wire eth_pkg::beat_t s0_beat,
  input  wire                 s0_beat_valid,
  output logic                s0_beat_ready,
  input  wire HDR_T           s1_hdr,
  input  wire                 s1_hdr_valid,
  output logic                s1_hdr_ready,
  input  wire eth_pkg::beat_t s1_beat,
  input  wire                 s1_beat_valid,
  output logic                s1_beat_ready,
  output HDR_T                m_hdr,
  output logic                m_hdr_valid,
  input  wire                 m_hdr_ready,
  output eth_pkg::beat_t      m_beat,
  output logic                m_beat_valid,
  input  wire                 m_beat_ready
);

  logic busy;
  logic grant;
  logic hdr_sent;
  logic req;
  logic sel;
  logic hdr_go;
  logic beat_done;

  assign req = s0_hdr_valid || s1_hdr_valid;

  // Lowest index wins while idle, the held grant otherwise
  assign sel = busy ? grant : !s0_hdr_valid;

  assign m_hdr       = sel ? s1_hdr : s0_hdr;
  assign m_hdr_valid = !hdr_sent && (sel ? s1_hdr_valid : s0_hdr_valid);

  assign hdr_go       = (busy || req) && !hdr_sent && m_hdr_ready;
  assign s0_hdr_ready = hdr_go && !sel;
  assign s1_hdr_ready = hdr_go && sel;

  // Beats only once the header is through
  assign m_beat        = sel ? s1_beat : s0_beat;
  assign m_beat_valid  = hdr_sent && (sel ? s1_beat_valid : s0_beat_valid);
  assign s0_beat_ready = hdr_sent && !sel && m_beat_ready;
  assign s1_beat_ready = hdr_sent && sel && m_beat_ready;
  assign beat_done     = m_beat_valid && m_beat_ready && m_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      grant    <= 1'b0;
      hdr_sent <= 1'b0;
    end else begin
      // Lock as soon as a header is offered so it stays steady downstream
      if (!busy && req) begin
        busy  <= 1'b1;
        grant <= sel;
      end
      if (m_hdr_valid && m_hdr_ready) begin
        hdr_sent <= 1'b1;
      end
      if (beat_done) begin
        busy     <= 1'b0;
        hdr_sent <= 1'b0;
      end
    end
  end

  // No switch of source inside an open frame
  a_grant_held : assert property (
    @(posedge clk) disable iff (rst)
    busy && !beat_done |=> busy && $stable(grant)
  );

  // An offered header is not withdrawn before it is taken
  a_hdr_kept : assert property (
    @(posedge clk) disable iff (rst)
    m_hdr_valid && !m_hdr_ready |=> m_hdr_valid
  );

endmodule

`default_nettype wire

//--- src/frame_demux.sv
// Routes each header-plus-payload frame to one of two outputs or drops it
`timescale 1ns/100ps
`default_nettype none

module frame_demux #(
  parameter type  HDR_T      = eth_pkg::eth_hdr_t,
  parameter type  KEY_T      = logic [15:0],
  parameter KEY_T MATCH_A    = '0,
  parameter KEY_T MATCH_B    = '0,
  parameter bit   DROP_OTHER = 1'b1
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire KEY_T           in_key,
  input  wire HDR_T           in_hdr,
  input  wire                 in_hdr_valid,
  output logic                in_hdr_ready,
  input  wire eth_pkg::beat_t in_beat,
  input  wire                 in_beat_valid,
  output logic                in_beat_ready,
  output HDR_T                a_hdr,
  output logic                a_hdr_valid,
  input  wire                 a_hdr_ready,
  output eth_pkg::beat_t      a_beat,
  output logic                a_beat_valid,
  input  wire                 a_beat_ready,
  output HDR_T                b_hdr,
  output logic                b_hdr_valid,
  input  wire                 b_hdr_ready,
  output eth_pkg::beat_t      b_beat,
  output logic                b_beat_valid,
  input  wire                 b_beat_ready
);

  logic hit_a;
  logic hit_b;
  logic busy;
  logic route_a;
  logic route_b;
  logic hdr_take;
  logic beat_done;

  // Without dropping, everything that misses A goes to B
  assign hit_a = (in_key == MATCH_A);
  assign hit_b = DROP_OTHER ? (!hit_a && (in_key == MATCH_B)) : !hit_a;

  // Headers only between frames
  assign a_hdr       = in_hdr;
  assign b_hdr       = in_hdr;
  assign a_hdr_valid = in_hdr_valid && !busy && hit_a;
  assign b_hdr_valid = in_hdr_valid && !busy && hit_b;

  assign in_hdr_ready = in_hdr_valid && !busy &&
                        (hit_a ? a_hdr_ready : (hit_b ? b_hdr_ready : 1'b1));
  assign hdr_take     = in_hdr_valid && in_hdr_ready;

  // Payload follows the stored route
  assign a_beat       = in_beat;
  assign b_beat       = in_beat;
  assign a_beat_valid = in_beat_valid && busy && route_a;
  assign b_beat_valid = in_beat_valid && busy && route_b;

  // unrouted frames drain one beat per cycle
  assign in_beat_ready = busy &&
                         (route_a ? a_beat_ready : (route_b ? b_beat_ready : 1'b1));
  assign beat_done     = in_beat_valid && in_beat_ready && in_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      route_a <= 1'b0;
      route_b <= 1'b0;
    end else if (hdr_take) begin
      busy    <= 1'b1;
      route_a <= hit_a;
      route_b <= hit_b;
    end else if (beat_done) begin
      busy    <= 1'b0;
    end
  end

  // Payload of one frame never shows up on both outputs
  a_one_output : assert property (
    @(posedge clk) disable iff (rst) !(a_beat_valid && b_beat_valid)
  );

endmodule

`default_nettype wire

//--- src/ip_pkg.sv
// IPv4 header fields and protocol numbers as seen on the decoded IP streams
`default_nettype none

package ip_pkg;

  // Only ICMP is told apart from the upper layers
  localparam logic [7:0] PROTO_ICMP = 8'd1;

  // Decoded header, 216 bits with the outer Ethernet header on top
  typedef struct packed {
    eth_pkg::eth_hdr_t eth_hdr;
    logic [5:0]        dscp;
    logic [1:0]        ecn;
    logic [15:0]       length;
    logic [7:0]        ttl;
    logic [7:0]        protocol;
    logic [31:0]       source_ip;
    logic [31:0]       dest_ip;
  } ip_hdr_t;

endpackage

`default_nettype wire

//--- src/ip_steer_top.sv
// Frame steering fabric between the Ethernet MAC and the IP, ARP and ICMP engines
`timescale 1ns/100ps
`default_nettype none

module ip_steer_top (
  input  wire                    clk,
  input  wire                    rst,
  input  wire eth_pkg::eth_hdr_t mac_rx_hdr,
  input  wire                    mac_rx_hdr_valid,
  output logic                   mac_rx_hdr_ready,
  input  wire eth_pkg::beat_t    mac_rx_beat,
  input  wire                    mac_rx_beat_valid,
  output logic                   mac_rx_beat_ready,
  output eth_pkg::eth_hdr_t      ip_eng_rx_hdr,
  output logic                   ip_eng_rx_hdr_valid,
  input  wire                    ip_eng_rx_hdr_ready,
  output eth_pkg::beat_t         ip_eng_rx_beat,
  output logic                   ip_eng_rx_beat_valid,
  input  wire                    ip_eng_rx_beat_ready,
  output eth_pkg::eth_hdr_t      arp_eng_rx_hdr,
  output logic                   arp_eng_rx_hdr_valid,
  input  wire                    arp_eng_rx_hdr_ready,
  output eth_pkg::beat_t         arp_eng_rx_beat,
  output logic                   arp_eng_rx_beat_valid,
  input  wire                    arp_eng_rx_beat_ready,
  input  wire ip_pkg::ip_hdr_t   ip_eng_dec_hdr,
  input  wire                    ip_eng_dec_hdr_valid,
  output logic                   ip_eng_dec_hdr_ready,
  input  wire eth_pkg::beat_t    ip_eng_dec_beat,
  input  wire                    ip_eng_dec_beat_valid,
  output logic                   ip_eng_dec_beat_ready,
  output ip_pkg::ip_hdr_t        icmp_rx_hdr,
  output logic                   icmp_rx_hdr_valid,
  input  wire                    icmp_rx_hdr_ready,
  output eth_pkg::beat_t         icmp_rx_beat,
  output logic                   icmp_rx_beat_valid,
  input  wire                    icmp_rx_beat_ready,
  output ip_pkg::ip_hdr_t        upper_rx_hdr,
  output logic                   upper_rx_hdr_valid,
  input  wire                    upper_rx_hdr_ready,
  output eth_pkg::beat_t         upper_rx_beat,
  output logic                   upper_rx_beat_valid,
  input  wire                    upper_rx_beat_ready,
  input  wire ip_pkg::ip_hdr_t   icmp_tx_hdr,
  input  wire                    icmp_tx_hdr_valid,
  output logic                   icmp_tx_hdr_ready,
  input  wire eth_pkg::beat_t    icmp_tx_beat,
  input  wire                    icmp_tx_beat_valid,
  output logic                   icmp_tx_beat_ready,
  input  wire ip_pkg::ip_hdr_t   user_tx_hdr,
  input  wire                    user_tx_hdr_valid,
  output logic                   user_tx_hdr_ready,
  input  wire eth_pkg::beat_t    user_tx_beat,
  input  wire                    user_tx_beat_valid,
  output logic                   user_tx_beat_ready,
  output ip_pkg::ip_hdr_t        ip_eng_tx_hdr,
  output logic                   ip_eng_tx_hdr_valid,
  input  wire                    ip_eng_tx_hdr_ready,
  output eth_pkg::beat_t         ip_eng_tx_beat,
  output logic                   ip_eng_tx_beat_valid,
  input  wire                    ip_eng_tx_beat_ready,
  input  wire eth_pkg::eth_hdr_t arp_eng_tx_hdr,
  input  wire                    arp_eng_tx_hdr_valid,
  output logic                   arp_eng_tx_hdr_ready,
  input  wire eth_pkg::beat_t    arp_eng_tx_beat,
  input  wire                    arp_eng_tx_beat_valid,
  output logic                   arp_eng_tx_beat_ready,
  input  wire eth_pkg::eth_hdr_t ip_eng_eth_tx_hdr,
  input  wire                    ip_eng_eth_tx_hdr_valid,
  output logic                   ip_eng_eth_tx_hdr_ready,
  input  wire eth_pkg::beat_t    ip_eng_eth_tx_beat,
  input  wire                    ip_eng_eth_tx_beat_valid,
  output logic                   ip_eng_eth_tx_beat_ready,
  output eth_pkg::eth_hdr_t      mac_tx_hdr,
  output logic                   mac_tx_hdr_valid,
  input  wire                    mac_tx_hdr_ready,
  output eth_pkg::beat_t         mac_tx_beat,
  output logic                   mac_tx_beat_valid,
  input  wire                    mac_tx_beat_ready
);

  import eth_pkg::*;
  import ip_pkg::*;

  // ARP payload after the register slice
  beat_t arp_skid_beat;
  logic  arp_skid_valid;
  logic  arp_skid_ready;

  // Receive split by ethertype, anything else is swallowed
  frame_demux #(
    .HDR_T(eth_hdr_t), .KEY_T(logic [15:0]),
    .MATCH_A(ETHERTYPE_IPV4), .MATCH_B(ETHERTYPE_ARP), .DROP_OTHER(1'b1)
  ) u_eth_demux (
    .clk(clk), .rst(rst), .in_key(mac_rx_hdr.eth_type),
    .in_hdr(mac_rx_hdr), .in_hdr_valid(mac_rx_hdr_valid), .in_hdr_ready(mac_rx_hdr_ready),
    .in_beat(mac_rx_beat), .in_beat_valid(mac_rx_beat_valid),
    .in_beat_ready(mac_rx_beat_ready),
    .a_hdr(ip_eng_rx_hdr), .a_hdr_valid(ip_eng_rx_hdr_valid),
    .a_hdr_ready(ip_eng_rx_hdr_ready), .a_beat(ip_eng_rx_beat),
    .a_beat_valid(ip_eng_rx_beat_valid), .a_beat_ready(ip_eng_rx_beat_ready),
    .b_hdr(arp_eng_rx_hdr), .b_hdr_valid(arp_eng_rx_hdr_valid),
    .b_hdr_ready(arp_eng_rx_hdr_ready), .b_beat(arp_eng_rx_beat),
    .b_beat_valid(arp_eng_rx_beat_valid), .b_beat_ready(arp_eng_rx_beat_ready)
  );

  // Decoded IP split, ICMP to the echo port and the rest upward
  frame_demux #(
    .HDR_T(ip_hdr_t), .KEY_T(logic [7:0]),
    .MATCH_A(PROTO_ICMP), .MATCH_B(8'h00), .DROP_OTHER(1'b0)
  ) u_proto_demux (
    .clk(clk), .rst(rst), .in_key(ip_eng_dec_hdr.protocol),
    .in_hdr(ip_eng_dec_hdr), .in_hdr_valid(ip_eng_dec_hdr_valid),
    .in_hdr_ready(ip_eng_dec_hdr_ready), .in_beat(ip_eng_dec_beat),
    .in_beat_valid(ip_eng_dec_beat_valid), .in_beat_ready(ip_eng_dec_beat_ready),
    .a_hdr(icmp_rx_hdr), .a_hdr_valid(icmp_rx_hdr_valid), .a_hdr_ready(icmp_rx_hdr_ready),
    .a_beat(icmp_rx_beat), .a_beat_valid(icmp_rx_beat_valid),
    .a_beat_ready(icmp_rx_beat_ready),
    .b_hdr(upper_rx_hdr), .b_hdr_valid(upper_rx_hdr_valid),
    .b_hdr_ready(upper_rx_hdr_ready), .b_beat(upper_rx_beat),
    .b_beat_valid(upper_rx_beat_valid), .b_beat_ready(upper_rx_beat_ready)
  );

  // ICMP replies ahead of user traffic
  frame_arbiter #(
    .HDR_T(ip_hdr_t)
  ) u_ip_tx_arb (
    .clk(clk), .rst(rst),
    .s0_hdr(icmp_tx_hdr), .s0_hdr_valid(icmp_tx_hdr_valid), .s0_hdr_ready(icmp_tx_hdr_ready),
    .s0_beat(icmp_tx_beat), .s0_beat_valid(icmp_tx_beat_valid),
    .s0_beat_ready(icmp_tx_beat_ready),
    .s1_hdr(user_tx_hdr), .s1_hdr_valid(user_tx_hdr_valid), .s1_hdr_ready(user_tx_hdr_ready),
    .s1_beat(user_tx_beat), .s1_beat_valid(user_tx_beat_valid),
    .s1_beat_ready(user_tx_beat_ready),
    .m_hdr(ip_eng_tx_hdr), .m_hdr_valid(ip_eng_tx_hdr_valid),
    .m_hdr_ready(ip_eng_tx_hdr_ready), .m_beat(ip_eng_tx_beat),
    .m_beat_valid(ip_eng_tx_beat_valid), .m_beat_ready(ip_eng_tx_beat_ready)
  );

  skid_register #(
    .BEAT_T(beat_t)
  ) u_arp_skid (
    .clk(clk), .rst(rst),
    .in_beat(arp_eng_tx_beat), .in_valid(arp_eng_tx_beat_valid),
    .in_ready(arp_eng_tx_beat_ready),
    .out_beat(arp_skid_beat), .out_valid(arp_skid_valid), .out_ready(arp_skid_ready)
  );

  // ARP first into the MAC
  frame_arbiter #(
    .HDR_T(eth_hdr_t)
  ) u_eth_tx_arb (
    .clk(clk), .rst(rst),
    .s0_hdr(arp_eng_tx_hdr), .s0_hdr_valid(arp_eng_tx_hdr_valid),
    .s0_hdr_ready(arp_eng_tx_hdr_ready), .s0_beat(arp_skid_beat),
    .s0_beat_valid(arp_skid_valid), .s0_beat_ready(arp_skid_ready),
    .s1_hdr(ip_eng_eth_tx_hdr), .s1_hdr_valid(ip_eng_eth_tx_hdr_valid),
    .s1_hdr_ready(ip_eng_eth_tx_hdr_ready), .s1_beat(ip_eng_eth_tx_beat),
    .s1_beat_valid(ip_eng_eth_tx_beat_valid), .s1_beat_ready(ip_eng_eth_tx_beat_ready),
    .m_hdr(mac_tx_hdr), .m_hdr_valid(mac_tx_hdr_valid), .m_hdr_ready(mac_tx_hdr_ready),
    .m_beat(mac_tx_beat), .m_beat_valid(mac_tx_beat_valid), .m_beat_ready(mac_tx_beat_ready)
  );

endmodule

`default_nettype wire

//--- src/skid_register.sv
// Two-entry register slice for a payload stream with full throughput
`timescale 1ns/100ps
`default_nettype none

module skid_register #(
  parameter type BEAT_T = logic [7:0]
) (
  input  wire        clk,
  input  wire        rst,
  input  wire BEAT_T in_beat,
  input  wire        in_valid,
  output logic       in_ready,
  output BEAT_T      out_beat,
  output logic       out_valid,
  input  wire        out_ready
);

  BEAT_T skid_beat;
  logic  skid_valid;
  logic  load_main;
  logic  take;

  // Main register free or draining this cycle
  assign load_main = out_ready || !out_valid;
  assign take      = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else if (load_main) begin
      out_valid  <= skid_valid || take;
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else if (take) begin
      // Output stalled, park the beat
      skid_valid <= 1'b1;
      in_ready   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      out_beat <= skid_valid ? skid_beat : in_beat;
    end
    if (take && !load_main) begin
      skid_beat <= in_beat;
    end
  end

  // Full means both entries hold a beat
  a_no_overrun : assert property (
    @(posedge clk) disable iff (rst) take |-> !skid_valid
  );

endmodule

`default_nettype wire

//--- test/tb_ip_steer.sv
// Directed testbench for the frame steering fabric between MAC and protocol engines
`timescale 1ns/100ps
`default_nettype none

module tb_ip_steer;

  import eth_pkg::*;
  import ip_pkg::*;

  // Beats of all five tests together
  localparam int TOTAL_BEATS = 35;

  logic clk;
  logic rst;

  // Sources: mac_rx, ip_eng_dec, icmp_tx, user_tx, arp_eng_tx, ip_eng_eth_tx
  logic  [5:0][215:0] src_h;
  logic  [5:0]        src_hv;
  wire   [5:0]        src_hr;
  beat_t [5:0]        src_b;
  logic  [5:0]        src_bv;
  wire   [5:0]        src_br;

  // Sinks: ip_eng_rx, arp_eng_rx, icmp_rx, upper_rx, ip_eng_tx, mac_tx
  wire  [5:0][215:0] snk_h;
  wire  [5:0]        snk_hv;
  wire  [5:0][73:0]  snk_b;
  wire  [5:0]        snk_bv;
  logic [5:0]        snk_rdy = '0;
  logic [5:0]        stall_en = '0;

  // Payload beats of every frame built so far
  beat_t        pool[$];
  // Sink index on top of each header and beat
  logic [218:0] exp_hdr[$];
  logic [218:0] got_hdr[$];
  logic [76:0]  exp_beat[$];
  logic [76:0]  got_beat[$];
  int           n_pass = 0;
  int           n_fail = 0;

  ip_steer_top u_dut (
    .clk(clk), .rst(rst),
    .mac_rx_hdr(src_h[0][111:0]), .mac_rx_hdr_valid(src_hv[0]),
    .mac_rx_hdr_ready(src_hr[0]), .mac_rx_beat(src_b[0]),
    .mac_rx_beat_valid(src_bv[0]), .mac_rx_beat_ready(src_br[0]),
    .ip_eng_rx_hdr(snk_h[0][111:0]), .ip_eng_rx_hdr_valid(snk_hv[0]),
    .ip_eng_rx_hdr_ready(snk_rdy[0]), .ip_eng_rx_beat(snk_b[0]),
    .ip_eng_rx_beat_valid(snk_bv[0]), .ip_eng_rx_beat_ready(snk_rdy[0]),
    .arp_eng_rx_hdr(snk_h[1][111:0]), .arp_eng_rx_hdr_valid(snk_hv[1]),
    .arp_eng_rx_hdr_ready(snk_rdy[1]), .arp_eng_rx_beat(snk_b[1]),
    .arp_eng_rx_beat_valid(snk_bv[1]), .arp_eng_rx_beat_ready(snk_rdy[1]),
    .ip_eng_dec_hdr(src_h[1]), .ip_eng_dec_hdr_valid(src_hv[1]),
    .ip_eng_dec_hdr_ready(src_hr[1]), .ip_eng_dec_beat(src_b[1]),
    .ip_eng_dec_beat_valid(src_bv[1]), .ip_eng_dec_beat_ready(src_br[1]),
    .icmp_rx_hdr(snk_h[2]), .icmp_rx_hdr_valid(snk_hv[2]),
    .icmp_rx_hdr_ready(snk_rdy[2]), .icmp_rx_beat(snk_b[2]),
    .icmp_rx_beat_valid(snk_bv[2]), .icmp_rx_beat_ready(snk_rdy[2]),
    .upper_rx_hdr(snk_h[3]), .upper_rx_hdr_valid(snk_hv[3]),
    .upper_rx_hdr_ready(snk_rdy[3]), .upper_rx_beat(snk_b[3]),
    .upper_rx_beat_valid(snk_bv[3]), .upper_rx_beat_ready(snk_rdy[3]),
    .icmp_tx_hdr(src_h[2]), .icmp_tx_hdr_valid(src_hv[2]),
    .icmp_tx_hdr_ready(src_hr[2]), .icmp_tx_beat(src_b[2]),
    .icmp_tx_beat_valid(src_bv[2]), .icmp_tx_beat_ready(src_br[2]),
    .user_tx_hdr(src_h[3]), .user_tx_hdr_valid(src_hv[3]),
    .user_tx_hdr_ready(src_hr[3]), .user_tx_beat(src_b[3]),
    .user_tx_beat_valid(src_bv[3]), .user_tx_beat_ready(src_br[3]),
    .ip_eng_tx_hdr(snk_h[4]), .ip_eng_tx_hdr_valid(snk_hv[4]),
    .ip_eng_tx_hdr_ready(snk_rdy[4]), .ip_eng_tx_beat(snk_b[4]),
    .ip_eng_tx_beat_valid(snk_bv[4]), .ip_eng_tx_beat_ready(snk_rdy[4]),
    .arp_eng_tx_hdr(src_h[4][111:0]), .arp_eng_tx_hdr_valid(src_hv[4]),
    .arp_eng_tx_hdr_ready(src_hr[4]), .arp_eng_tx_beat(src_b[4]),
    .arp_eng_tx_beat_valid(src_bv[4]), .arp_eng_tx_beat_ready(src_br[4]),
    .ip_eng_eth_tx_hdr(src_h[5][111:0]), .ip_eng_eth_tx_hdr_valid(src_hv[5]),
    .ip_eng_eth_tx_hdr_ready(src_hr[5]), .ip_eng_eth_tx_beat(src_b[5]),
    .ip_eng_eth_tx_beat_valid(src_bv[5]), .ip_eng_eth_tx_beat_ready(src_br[5]),
    .mac_tx_hdr(snk_h[5][111:0]), .mac_tx_hdr_valid(snk_hv[5]),
    .mac_tx_hdr_ready(snk_rdy[5]), .mac_tx_beat(snk_b[5]),
    .mac_tx_beat_valid(snk_bv[5]), .mac_tx_beat_ready(snk_rdy[5])
  );

  // Ethernet sinks only fill the low 112 bits
  assign snk_h[0][215:112] = '0;
  assign snk_h[1][215:112] = '0;
  assign snk_h[5][215:112] = '0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Transfers are logged half a cycle before the edge that completes them
  always @(negedge clk) begin
    for (int k = 0; k < 6; k++) begin
      if (!rst && snk_hv[k] && snk_rdy[k]) got_hdr.push_back({3'(k), snk_h[k]});
      if (!rst && snk_bv[k] && snk_rdy[k]) got_beat.push_back({3'(k), snk_b[k]});
    end
  end

  always @(posedge clk) begin
    for (int k = 0; k < 6; k++) begin
      snk_rdy[k] <= stall_en[k] ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  function automatic logic [215:0] eth_header(input logic [15:0] eth_type);
    eth_hdr_t h;
    h.dest_mac = {16'h0200, $urandom};
    h.src_mac  = {16'h0200, $urandom};
    h.eth_type = eth_type;
    return 216'(h);
  endfunction

  function automatic logic [215:0] ip_header(input logic [7:0] proto);
    ip_hdr_t h;
    h = '0;
    h.eth_hdr.dest_mac = {16'h0200, $urandom};
    h.eth_hdr.src_mac  = {16'h0200, $urandom};
    h.eth_hdr.eth_type = ETHERTYPE_IPV4;
    h.length    = 16'(20 + $urandom % 1480);
    h.ttl       = 8'd64;
    h.protocol  = proto;
    h.source_ip = $urandom;
    h.dest_ip   = $urandom;
    return h;
  endfunction

  // Appends n random beats to the pool, returns the first index
  function automatic int new_frame(input int n);
    beat_t b;
    int    first;
    first = pool.size();
    for (int i = 0; i < n; i++) begin
      b.data = {$urandom, $urandom};
      b.last = (i == n - 1);
      b.keep = b.last ? 8'hff >> ($urandom % 8) : 8'hff;
      b.user = b.last && ($urandom % 4 == 0);
      pool.push_back(b);
    end
    return first;
  endfunction

  function automatic void expect_frame(input int d, input logic [215:0] hdr,
                                       input int first, input int n);
    exp_hdr.push_back({3'(d), hdr});
    for (int i = 0; i < n; i++) begin
      exp_beat.push_back({3'(d), pool[first + i]});
    end
  endfunction

  // Ready at the falling edge still holds at the next rising edge
  task automatic wait_accept(input int s, input bit is_beat);
    logic ok;
    do begin
      @(negedge clk);
      ok = is_beat ? src_br[s] : src_hr[s];
      @(posedge clk);
    end while (!ok);
  endtask

  task automatic send_frame(input int s, input logic [215:0] hdr, input int first, input int n);
    src_h[s]  <= hdr;
    src_hv[s] <= 1'b1;
    wait_accept(s, 1'b0);
    src_hv[s] <= 1'b0;
    for (int i = 0; i < n; i++) begin
      src_b[s]  <= pool[first + i];
      src_bv[s] <= 1'b1;
      wait_accept(s, 1'b1);
    end
    src_bv[s] <= 1'b0;
  endtask

  // Negative sink index means the frame must vanish
  task automatic route_frame(input int s, input int d, input logic [215:0] hdr, input int n);
    int first;
    first = new_frame(n);
    if (d >= 0) begin
      expect_frame(d, hdr, first, n);
    end
    send_frame(s, hdr, first, n);
  endtask

  task automatic compare_results(input string name);
    int errs;
    errs = 0;
    while (got_beat.size() < exp_beat.size()) @(posedge clk);
    // Room for anything that should not arrive
    repeat (4) @(posedge clk);
    if (got_hdr.size() != exp_hdr.size()) begin
      $display("mismatch %s: header count expected %0d actual %0d",
               name, exp_hdr.size(), got_hdr.size());
      errs++;
    end
    if (got_beat.size() != exp_beat.size()) begin
      $display("mismatch %s: beat count expected %0d actual %0d",
               name, exp_beat.size(), got_beat.size());
      errs++;
    end
    for (int i = 0; i < exp_hdr.size() && i < got_hdr.size(); i++) begin
      if (got_hdr[i] != exp_hdr[i]) begin
        $display("mismatch %s: header %0d expected %h actual %h",
                 name, i, exp_hdr[i], got_hdr[i]);
        errs++;
      end
    end
    for (int i = 0; i < exp_beat.size() && i < got_beat.size(); i++) begin
      if (got_beat[i] != exp_beat[i]) begin
        $display("mismatch %s: beat %0d expected %h actual %h",
                 name, i, exp_beat[i], got_beat[i]);
        errs++;
      end
    end
    if (errs == 0) begin
      $display("%s: ok", name);
      n_pass++;
    end else begin
      $display("%s: %0d errors", name, errs);
      n_fail++;
    end
    exp_hdr.delete();
    got_hdr.delete();
    exp_beat.delete();
    got_beat.delete();
  endtask

  task automatic split_by_ethertype();
    route_frame(0, 0, eth_header(ETHERTYPE_IPV4), 3);
    route_frame(0, 1, eth_header(ETHERTYPE_ARP), 2);
    compare_results("split_by_ethertype");
  endtask

  task automatic drop_unknown_type();
    // IPv6 has no port here
    route_frame(0, -1, eth_header(16'h86dd), 4);
    route_frame(0, 0, eth_header(ETHERTYPE_IPV4), 2);
    compare_results("drop_unknown_type");
  endtask

  task automatic split_by_protocol();
    route_frame(1, 2, ip_header(PROTO_ICMP), 2);
    route_frame(1, 3, ip_header(8'd6), 3);
    route_frame(1, 3, ip_header(8'd17), 1);
    compare_results("split_by_protocol");
  endtask

  task automatic merge_mac_tx();
    logic [215:0] h_arp;
    logic [215:0] h_ip;
    int           f_arp;
    int           f_ip;
    h_arp = eth_header(ETHERTYPE_ARP);
    h_ip  = eth_header(ETHERTYPE_IPV4);
    f_arp = new_frame(3);
    f_ip  = new_frame(4);
    // ARP is index 0, so it goes first
    expect_frame(5, h_arp, f_arp, 3);
    expect_frame(5, h_ip, f_ip, 4);
    fork
      send_frame(4, h_arp, f_arp, 3);
      send_frame(5, h_ip, f_ip, 4);
    join
    compare_results("merge_mac_tx");
  endtask

  task automatic merge_ip_tx();
    logic [215:0] h[4];
    int           f[4];
    int           lens[4] = '{3, 2, 4, 2};
    // ICMP re-offers on the release edge and wins the tie again
    for (int i = 0; i < 4; i++) begin
      h[i] = ip_header(i < 2 ? PROTO_ICMP : 8'd17);
      f[i] = new_frame(lens[i]);
      expect_frame(4, h[i], f[i], lens[i]);
    end
    fork
      begin
        send_frame(2, h[0], f[0], lens[0]);
        send_frame(2, h[1], f[1], lens[1]);
      end
      begin
        send_frame(3, h[2], f[2], lens[2]);
        send_frame(3, h[3], f[3], lens[3]);
      end
    join
    compare_results("merge_ip_tx");
  endtask

  initial begin
    void'($urandom(32'h12e8_7ec1));
    rst    = 1'b1;
    src_h  = '0;
    src_hv = '0;
    src_b  = '0;
    src_bv = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    split_by_ethertype();
    drop_unknown_type();
    split_by_protocol();
    // Random back-pressure on ip_eng_tx and mac_tx
    stall_en <= 6'b110000;
    merge_mac_tx();
    merge_ip_tx();
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // 200 cycles per beat sent
  initial begin
    repeat (200 * TOTAL_BEATS) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", 200 * TOTAL_BEATS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
